/* files.f */
verilog/cache_geom_pkg.sv
verilog/native_bus_pkg.sv
verilog/native_mem_if.sv
verilog/cache_memory.sv
verilog/cache_control.sv
verilog/write_buffer.sv
verilog/write_channel_native.sv
verilog/read_channel_native.sv
verilog/back_end_native.sv
verilog/iob_cache_top.sv
verification/tb_iob_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_iob_cache \
   -f files.f \
   -o sim_tb

# The testbench exits through $fatal on an error, so the log decides
./obj_dir/sim_tb | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi

echo "Simulation finished without a reported failure"

/* verification/tb_iob_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_iob_cache;

   localparam int FE_AW = cache_geom_pkg::FE_ADDR_W;
   localparam int FE_DW = cache_geom_pkg::FE_DATA_W;
   localparam int FE_NB = cache_geom_pkg::FE_NBYTES;
   localparam int FE_BW = $clog2(FE_NB);
   localparam int BE_AW = native_bus_pkg::BE_ADDR_W;
   localparam int BE_DW = native_bus_pkg::BE_DATA_W;
   localparam int BE_NB = native_bus_pkg::BE_NBYTES;
   localparam int BE_BW = native_bus_pkg::BE_BYTE_W;

   localparam int RESET_CYCLES = 16;
   localparam int NUM_OPS = 24;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 64 + RESET_CYCLES;
   localparam logic [31:0] LFSR_SEED = 32'd85867;
   localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

   localparam logic RD = 1'b0;
   localparam logic WR = 1'b1;
   localparam logic NO_FILL = 1'b0;
   localparam logic FILL = 1'b1;

   logic             clk;
   logic             reset;
   logic             valid;
   logic [FE_AW-1:0] addr;
   logic [FE_DW-1:0] wdata;
   logic [FE_NB-1:0] wstrb;
   logic             ready;
   logic [FE_DW-1:0] rdata;
   logic             mem_valid;
   logic [BE_AW-1:0] mem_addr;
   logic [BE_DW-1:0] mem_wdata;
   logic [BE_NB-1:0] mem_wstrb;
   logic             mem_ready;
   logic [BE_DW-1:0] mem_rdata;

   logic [BE_DW-1:0] mem_words [2**(BE_AW-BE_BW)];
   logic [FE_DW-1:0] shadow [2**(FE_AW-FE_BW)];
   // Row is write flag, address, write data, strobe, refill expected
   logic [53:0]      stim_table [NUM_OPS];

   logic [BE_AW-1:0] exp_waddr [$];
   logic [BE_DW-1:0] exp_wdata [$];
   logic [BE_NB-1:0] exp_wstrb [$];
   logic [BE_AW-1:0] be_reads [$];

   logic [31:0]      lfsr_state;
   logic             ready_nxt;
   logic [BE_DW-1:0] rdata_nxt;
   int               cycle_count;

   iob_cache_top UUT (
      .clk(clk), .reset(reset), .valid(valid), .addr(addr), .wdata(wdata), .wstrb(wstrb),
      .ready(ready), .rdata(rdata), .mem_valid(mem_valid), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_ready(mem_ready),
      .mem_rdata(mem_rdata)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      lfsr_next = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
   endfunction

   // Every byte address starts with its own value
   function automatic logic [FE_DW-1:0] init_word(input logic [FE_AW-1:0] a);
      init_word = {a ^ 16'hC3A5, ~a};
   endfunction

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic take_bit(output logic b);
      b = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
   endtask

   task automatic check_fe_word(input logic [FE_AW-1:0] a, input logic [FE_DW-1:0] got,
                                input logic [FE_DW-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERROR at %0t ns: read of %h returned %h, expected %h",
                                     $time, a, got, exp));
   endtask

   task automatic check_be_read(input logic [BE_AW-1:0] got, input logic [BE_AW-1:0] exp);
      if (got !== exp)
         stop_with_failure($sformatf("ERROR at %0t ns: refill read at %h, expected %h",
                                     $time, got, exp));
   endtask

   task automatic check_be_write(input logic [BE_AW-1:0] a, input logic [BE_DW-1:0] data,
                                 input logic [BE_NB-1:0] strb);
      logic [BE_AW-1:0] exp_a;
      logic [BE_DW-1:0] exp_d;
      logic [BE_NB-1:0] exp_s;
      if (exp_waddr.size() == 0)
         stop_with_failure($sformatf("A memory write to %h arrived with no write pending", a));
      else
      begin
         exp_a = exp_waddr.pop_front();
         exp_d = exp_wdata.pop_front();
         exp_s = exp_wstrb.pop_front();
         if (a !== exp_a || data !== exp_d || strb !== exp_s)
            stop_with_failure($sformatf(
               "ERROR at %0t ns: memory write %h %h %h, expected %h %h %h",
               $time, a, data, strb, exp_a, exp_d, exp_s));
      end
   endtask

   // A refill reads the line base and then the next 64-bit word
   task automatic check_refill(input logic [FE_AW-1:0] a, input logic fill);
      logic [BE_AW-1:0] base;
      base = {a[FE_AW-1:4], 4'b0000};
      if (be_reads.size() != (fill ? 2 : 0))
         stop_with_failure($sformatf("ERROR at %0t ns: access to %h made %0d memory reads",
                                     $time, a, be_reads.size()));
      else if (fill)
      begin
         check_be_read(be_reads[0], base);
         check_be_read(be_reads[1], base + 16'd8);
      end
      be_reads.delete();
   endtask

   task automatic run_request(input logic [FE_AW-1:0] a, input logic [FE_DW-1:0] wd,
                              input logic [FE_NB-1:0] st, output logic [FE_DW-1:0] data);
      @(posedge clk);
      valid <= 1'b1;
      addr <= a;
      wdata <= wd;
      wstrb <= st;
      do
         @(negedge clk);
      while (!ready);
      data = rdata;
      @(posedge clk);
      valid <= 1'b0;
   endtask

   // Memory model decides mid-cycle and drives on the next rising edge
   always @(negedge clk)
   begin : mem_model
      logic stall_a;
      logic stall_b;
      if (reset)
         ready_nxt = 1'b0;
      else if (mem_valid && mem_ready)
      begin
         if (mem_wstrb != '0)
         begin
            check_be_write(mem_addr, mem_wdata, mem_wstrb);
            for (int b = 0; b < BE_NB; b++)
               if (mem_wstrb[b])
                  mem_words[mem_addr[BE_AW-1:BE_BW]][8*b +: 8] = mem_wdata[8*b +: 8];
         end
         else
            be_reads.push_back(mem_addr);
         ready_nxt = 1'b0;
      end
      else if (mem_valid)
      begin
         take_bit(stall_a);
         take_bit(stall_b);
         ready_nxt = stall_a && stall_b;
         rdata_nxt = mem_words[mem_addr[BE_AW-1:BE_BW]];
      end
      else
         ready_nxt = 1'b0;
   end

   always @(posedge clk)
   begin
      mem_ready <= ready_nxt;
      mem_rdata <= rdata_nxt;
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
         stop_with_failure($sformatf("Timeout: the run did not finish in %0d cycles",
                                     TIMEOUT_CYCLES));
   end

   initial
   begin
      logic [FE_AW-1:0] a;
      logic [FE_DW-1:0] wd;
      logic [FE_NB-1:0] st;
      logic [FE_DW-1:0] got;
      clk = 1'b0;
      reset = 1'b1;
      valid = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      mem_ready = 1'b0;
      mem_rdata = '0;
      lfsr_state = LFSR_SEED;
      ready_nxt = 1'b0;
      rdata_nxt = '0;
      cycle_count = 0;

      stim_table = '{
         {RD, 16'h1230, 32'h0000_0000, 4'b0000, FILL},
         {RD, 16'h1234, 32'h0000_0000, 4'b0000, NO_FILL},
         {RD, 16'h123C, 32'h0000_0000, 4'b0000, NO_FILL},
         {WR, 16'h1238, 32'hDEAD_BEEF, 4'b1111, NO_FILL},
         {WR, 16'h123C, 32'h0BAD_F00D, 4'b1111, NO_FILL},
         {RD, 16'h1238, 32'h0000_0000, 4'b0000, NO_FILL},
         {WR, 16'h1234, 32'hAABB_CCDD, 4'b0101, NO_FILL},
         {RD, 16'h1234, 32'h0000_0000, 4'b0000, NO_FILL},
         {WR, 16'h1230, 32'h1122_3344, 4'b1000, NO_FILL},
         {RD, 16'h1230, 32'h0000_0000, 4'b0000, NO_FILL},
         // Burst into a line that is not cached
         {WR, 16'h4500, 32'h0101_0101, 4'b1111, NO_FILL},
         {WR, 16'h4504, 32'h0202_0202, 4'b0011, NO_FILL},
         {WR, 16'h4508, 32'h0303_0303, 4'b1100, NO_FILL},
         {WR, 16'h450C, 32'h0404_0404, 4'b1111, NO_FILL},
         {WR, 16'h4510, 32'h0505_0505, 4'b1111, NO_FILL},
         {RD, 16'h4504, 32'h0000_0000, 4'b0000, FILL},
         {RD, 16'h450C, 32'h0000_0000, 4'b0000, NO_FILL},
         {RD, 16'h4500, 32'h0000_0000, 4'b0000, NO_FILL},
         {WR, 16'h7F48, 32'hCAFE_BABE, 4'b0110, NO_FILL},
         {RD, 16'h7F48, 32'h0000_0000, 4'b0000, FILL},
         {RD, 16'h7F4C, 32'h0000_0000, 4'b0000, NO_FILL},
         // Same index as 0x1230 with another tag, then back again
         {RD, 16'h9930, 32'h0000_0000, 4'b0000, FILL},
         {RD, 16'h1234, 32'h0000_0000, 4'b0000, FILL},
         {RD, 16'h4510, 32'h0000_0000, 4'b0000, FILL}
      };

      for (int w = 0; w < 2**(BE_AW-BE_BW); w++)
         mem_words[w] = {init_word({w[BE_AW-BE_BW-1:0], 3'b100}),
                         init_word({w[BE_AW-BE_BW-1:0], 3'b000})};
      for (int i = 0; i < 2**(FE_AW-FE_BW); i++)
         shadow[i] = init_word({i[FE_AW-FE_BW-1:0], 2'b00});

      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      for (int n = 0; n < NUM_OPS; n++)
      begin
         a = stim_table[n][52:37];
         wd = stim_table[n][36:5];
         st = stim_table[n][4:1];
         if (stim_table[n][53] == WR)
         begin
            // Write-through puts the word into its half of the 64-bit memory word
            exp_waddr.push_back({a[FE_AW-1:BE_BW], 3'b000});
            exp_wdata.push_back(a[2] ? {wd, 32'h0} : {32'h0, wd});
            exp_wstrb.push_back(a[2] ? {st, 4'h0} : {4'h0, st});
            for (int b = 0; b < FE_NB; b++)
               if (st[b])
                  shadow[a[FE_AW-1:FE_BW]][8*b +: 8] = wd[8*b +: 8];
         end
         run_request(a, wd, st, got);
         if (stim_table[n][53] == RD)
            check_fe_word(a, got, shadow[a[FE_AW-1:FE_BW]]);
         check_refill(a, stim_table[n][0]);
      end

      while (exp_waddr.size() != 0)
         @(negedge clk);

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/iob_cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module iob_cache_top (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire                                  valid,
   input  wire  [cache_geom_pkg::FE_ADDR_W-1:0] addr,
   input  wire  [cache_geom_pkg::FE_DATA_W-1:0] wdata,
   input  wire  [cache_geom_pkg::FE_NBYTES-1:0] wstrb,
   output logic                                 ready,
   output logic [cache_geom_pkg::FE_DATA_W-1:0] rdata,
   output logic                                 mem_valid,
   output logic [native_bus_pkg::BE_ADDR_W-1:0] mem_addr,
   output logic [native_bus_pkg::BE_DATA_W-1:0] mem_wdata,
   output logic [native_bus_pkg::BE_NBYTES-1:0] mem_wstrb,
   input  wire                                  mem_ready,
   input  wire  [native_bus_pkg::BE_DATA_W-1:0] mem_rdata
);

   logic                                              hit;
   logic [cache_geom_pkg::FE_DATA_W-1:0]              rd_word;
   logic                                              push;
   logic                                              wr_en;
   logic                                              wbuf_full;
   logic                                              wbuf_empty;
   logic                                              refill_start;
   logic                                              refill_done;
   logic                                              beat_en;
   logic [$clog2(native_bus_pkg::BEATS_PER_LINE)-1:0] beat_idx;
   logic [native_bus_pkg::BE_DATA_W-1:0]              beat_data;

   native_mem_if #(.DATA_W(cache_geom_pkg::FE_DATA_W)) wbuf_out ();
   native_mem_if #(.DATA_W(native_bus_pkg::BE_DATA_W)) wr_be ();
   native_mem_if #(.DATA_W(native_bus_pkg::BE_DATA_W)) rd_be ();

   cache_control control (
      .clk(clk), .reset(reset), .valid(valid), .addr(addr), .wdata(wdata), .wstrb(wstrb),
      .hit(hit), .rd_word(rd_word), .wbuf_full(wbuf_full), .wbuf_empty(wbuf_empty),
      .refill_done(refill_done), .ready(ready), .rdata(rdata), .push(push),
      .wr_en(wr_en), .refill_start(refill_start)
   );

   cache_memory memory (
      .clk(clk), .reset(reset), .lookup_addr(addr), .wr_en(wr_en), .wr_strb(wstrb),
      .wr_data(wdata), .fill_en(beat_en), .fill_beat(beat_idx), .fill_data(beat_data),
      .fill_done(refill_done), .hit(hit), .rd_word(rd_word)
   );

   write_buffer wbuf (
      .clk(clk), .reset(reset), .push(push), .addr(addr), .wdata(wdata), .wstrb(wstrb),
      .full(wbuf_full), .empty(wbuf_empty), .out(wbuf_out)
   );

   write_channel_native write_channel (.clk(clk), .reset(reset), .fe(wbuf_out), .be(wr_be));

   read_channel_native read_channel (
      .clk(clk), .reset(reset), .start(refill_start), .line_addr(addr), .beat_en(beat_en),
      .beat_idx(beat_idx), .beat_data(beat_data), .done(refill_done), .be(rd_be)
   );

   back_end_native back_end (
      .clk(clk), .reset(reset), .wr(wr_be), .rd(rd_be), .mem_valid(mem_valid),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
      .mem_ready(mem_ready), .mem_rdata(mem_rdata)
   );

endmodule

`default_nettype wire

/* verilog/back_end_native.sv */
`timescale 1ns/1ns
`default_nettype none

module back_end_native (
   input  wire                                  clk,
   input  wire                                  reset,
   native_mem_if.slave                          wr,
   native_mem_if.slave                          rd,
   output logic                                 mem_valid,
   output logic [native_bus_pkg::BE_ADDR_W-1:0] mem_addr,
   output logic [native_bus_pkg::BE_DATA_W-1:0] mem_wdata,
   output logic [native_bus_pkg::BE_NBYTES-1:0] mem_wstrb,
   input  wire                                  mem_ready,
   input  wire  [native_bus_pkg::BE_DATA_W-1:0] mem_rdata
);

   logic grant_wr;

   // Writes win, though control never lets a refill overlap a drain
   assign grant_wr = wr.valid;

   assign mem_valid = wr.valid || rd.valid;
   assign mem_addr = grant_wr ? wr.addr : rd.addr;
   assign mem_wdata = grant_wr ? wr.wdata : rd.wdata;
   assign mem_wstrb = grant_wr ? wr.wstrb : rd.wstrb;

   assign wr.ready = grant_wr && mem_ready;
   assign rd.ready = !grant_wr && mem_ready;
   assign wr.rdata = mem_rdata;
   assign rd.rdata = mem_rdata;

   assert property (@(posedge clk) disable iff (reset) !(wr.valid && rd.valid));

endmodule

`default_nettype wire

/* verilog/read_channel_native.sv */
`timescale 1ns/1ns
`default_nettype none

module read_channel_native (
   input  wire                                              clk,
   input  wire                                              reset,
   input  wire                                              start,
   input  wire  [native_bus_pkg::BE_ADDR_W-1:0]             line_addr,
   output logic                                             beat_en,
   output logic [$clog2(native_bus_pkg::BEATS_PER_LINE)-1:0] beat_idx,
   output logic [native_bus_pkg::BE_DATA_W-1:0]             beat_data,
   output logic                                             done,
   native_mem_if.master                                     be
);

   enum logic [1:0] {idle, request, finish} state;

   logic [$clog2(native_bus_pkg::BEATS_PER_LINE)-1:0] beat_cnt;

   // Beat address is the line base with the beat number above the byte offset
   assign be.addr = {line_addr[native_bus_pkg::BE_ADDR_W-1:
                               native_bus_pkg::BE_BYTE_W+$clog2(native_bus_pkg::BEATS_PER_LINE)],
                     beat_cnt, {native_bus_pkg::BE_BYTE_W{1'b0}}};
   assign be.valid = (state == request);
   assign be.wdata = '0;
   assign be.wstrb = '0;

   assign beat_en = be.valid && be.ready;
   assign beat_idx = beat_cnt;
   assign beat_data = be.rdata;
   assign done = (state == finish);

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= idle;
         beat_cnt <= '0;
      end
      else
         case (state)
            idle:
               if (start)
               begin
                  beat_cnt <= '0;
                  state <= request;
               end
            request:
               if (be.ready)
               begin
                  if (&beat_cnt)
                     state <= finish;
                  else
                     beat_cnt <= beat_cnt + 1'b1;
               end
            finish:
               state <= idle;
            default:
               state <= idle;
         endcase
   end

endmodule

`default_nettype wire

/* verilog/write_channel_native.sv */
`timescale 1ns/1ns
`default_nettype none

module write_channel_native (
   input  wire         clk,
   input  wire         reset,
   native_mem_if.slave fe,
   native_mem_if.master be
);

   enum logic {idle, write_process} state;

   logic [cache_geom_pkg::FE_ADDR_W-1:0] addr_q;
   logic [cache_geom_pkg::FE_DATA_W-1:0] wdata_q;
   logic [cache_geom_pkg::FE_NBYTES-1:0] wstrb_q;
   logic                                 word_align;

   // Selects which 32-bit half of the 64-bit memory word is addressed
   assign word_align = addr_q[native_bus_pkg::BE_BYTE_W-1];

   assign fe.ready = (state == idle);
   assign fe.rdata = '0;

   assign be.valid = (state == write_process);
   assign be.addr = {addr_q[native_bus_pkg::BE_ADDR_W-1:native_bus_pkg::BE_BYTE_W],
                     {native_bus_pkg::BE_BYTE_W{1'b0}}};
   assign be.wdata = word_align ? {wdata_q, {cache_geom_pkg::FE_DATA_W{1'b0}}}
                                : {{cache_geom_pkg::FE_DATA_W{1'b0}}, wdata_q};

   always_comb
   begin
      be.wstrb = '0;
      if (state == write_process)
         be.wstrb = word_align ? {wstrb_q, {cache_geom_pkg::FE_NBYTES{1'b0}}}
                               : {{cache_geom_pkg::FE_NBYTES{1'b0}}, wstrb_q};
   end

   // The buffer pops its head in this cycle, so the entry is kept here
   always_ff @(posedge clk)
   begin
      if (fe.valid && fe.ready)
      begin
         addr_q <= fe.addr;
         wdata_q <= fe.wdata;
         wstrb_q <= fe.wstrb;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= idle;
      else
         case (state)
            idle:
               if (fe.valid)
                  state <= write_process;
            write_process:
               if (be.ready)
                  state <= idle;
            default:
               state <= idle;
         endcase
   end

   assert property (@(posedge clk) disable iff (reset) be.valid |-> (be.wstrb != '0));

endmodule

`default_nettype wire

/* verilog/write_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module write_buffer (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire                                  push,
   input  wire  [cache_geom_pkg::FE_ADDR_W-1:0] addr,
   input  wire  [cache_geom_pkg::FE_DATA_W-1:0] wdata,
   input  wire  [cache_geom_pkg::FE_NBYTES-1:0] wstrb,
   output logic                                 full,
   output logic                                 empty,
   native_mem_if.master                         out
);

   logic [cache_geom_pkg::FE_ADDR_W-1:0] addr_mem [native_bus_pkg::WBUF_DEPTH];
   logic [cache_geom_pkg::FE_DATA_W-1:0] data_mem [native_bus_pkg::WBUF_DEPTH];
   logic [cache_geom_pkg::FE_NBYTES-1:0] strb_mem [native_bus_pkg::WBUF_DEPTH];

   logic [native_bus_pkg::WBUF_PTR_W-1:0] wr_ptr;
   logic [native_bus_pkg::WBUF_PTR_W-1:0] rd_ptr;
   logic [native_bus_pkg::WBUF_PTR_W:0]   count;
   logic                                  pop;

   assign pop = out.valid && out.ready;

   assign out.valid = (count != '0);
   assign out.addr = addr_mem[rd_ptr];
   assign out.wdata = data_mem[rd_ptr];
   assign out.wstrb = strb_mem[rd_ptr];

   assign full = count[native_bus_pkg::WBUF_PTR_W];
   // Drained means no entry left and no write still in flight downstream
   assign empty = (count == '0) && out.ready;

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         addr_mem[wr_ptr] <= addr;
         data_mem[wr_ptr] <= wdata;
         strb_mem[wr_ptr] <= wstrb;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/cache_control.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_control (
   input  wire                                  clk,
   input  wire                                  reset,
   input  wire                                  valid,
   input  wire  [cache_geom_pkg::FE_ADDR_W-1:0] addr,
   input  wire  [cache_geom_pkg::FE_DATA_W-1:0] wdata,
   input  wire  [cache_geom_pkg::FE_NBYTES-1:0] wstrb,
   input  wire                                  hit,
   input  wire  [cache_geom_pkg::FE_DATA_W-1:0] rd_word,
   input  wire                                  wbuf_full,
   input  wire                                  wbuf_empty,
   input  wire                                  refill_done,
   output logic                                 ready,
   output logic [cache_geom_pkg::FE_DATA_W-1:0] rdata,
   output logic                                 push,
   output logic                                 wr_en,
   output logic                                 refill_start
);

   enum logic [2:0] {idle, read_respond, write_push, wait_drain, refill} state;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= idle;
      else
         case (state)
            idle:
               if (valid)
               begin
                  if (wstrb != '0)
                     state <= write_push;
                  else if (hit)
                     state <= read_respond;
                  else
                     state <= wait_drain;
               end
            read_respond:
               state <= idle;
            write_push:
               if (!wbuf_full)
                  state <= idle;
            // Memory must see every buffered write before the line is fetched
            wait_drain:
               if (wbuf_empty)
                  state <= refill;
            refill:
               if (refill_done)
                  state <= read_respond;
            default:
               state <= idle;
         endcase
   end

   assign push = (state == write_push) && !wbuf_full;
   assign wr_en = push && hit;
   assign ready = push || (state == read_respond);
   assign refill_start = (state == wait_drain) && wbuf_empty;
   assign rdata = rd_word;

   // A write is only accepted while the front end holds a request with data
   assert property (@(posedge clk) disable iff (reset)
      push |-> valid && (wstrb != '0) && (wdata == $past(wdata)) && (addr == $past(addr)));

endmodule

`default_nettype wire

/* verilog/cache_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_memory (
   input  wire                                              clk,
   input  wire                                              reset,
   input  wire  [cache_geom_pkg::FE_ADDR_W-1:0]             lookup_addr,
   input  wire                                              wr_en,
   input  wire  [cache_geom_pkg::FE_NBYTES-1:0]             wr_strb,
   input  wire  [cache_geom_pkg::FE_DATA_W-1:0]             wr_data,
   input  wire                                              fill_en,
   input  wire  [$clog2(native_bus_pkg::BEATS_PER_LINE)-1:0] fill_beat,
   input  wire  [native_bus_pkg::BE_DATA_W-1:0]             fill_data,
   input  wire                                              fill_done,
   output logic                                             hit,
   output logic [cache_geom_pkg::FE_DATA_W-1:0]             rd_word
);

   logic [cache_geom_pkg::TAG_W-1:0]     tag_mem [2**cache_geom_pkg::INDEX_W];
   logic [2**cache_geom_pkg::INDEX_W-1:0] valid_mem;
   logic [cache_geom_pkg::FE_DATA_W-1:0] data_mem
      [2**cache_geom_pkg::INDEX_W][2**cache_geom_pkg::WORD_OFF_W];

   logic [cache_geom_pkg::TAG_W-1:0]      tag;
   logic [cache_geom_pkg::INDEX_W-1:0]    index;
   logic [cache_geom_pkg::WORD_OFF_W-1:0] word_off;

   assign tag = lookup_addr[cache_geom_pkg::FE_ADDR_W-1 -: cache_geom_pkg::TAG_W];
   assign index = lookup_addr[cache_geom_pkg::FE_ADDR_W-cache_geom_pkg::TAG_W-1
      -: cache_geom_pkg::INDEX_W];
   assign word_off = lookup_addr[cache_geom_pkg::FE_ADDR_W-cache_geom_pkg::TAG_W
      -cache_geom_pkg::INDEX_W-1 -: cache_geom_pkg::WORD_OFF_W];

   assign hit = valid_mem[index] && (tag_mem[index] == tag);
   assign rd_word = data_mem[index][word_off];

   // A line only becomes valid once its last refill beat is in
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         valid_mem <= '0;
      else if (fill_done)
         valid_mem[index] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (fill_done)
         tag_mem[index] <= tag;
      if (wr_en)
      begin
         for (int b = 0; b < cache_geom_pkg::FE_NBYTES; b++)
            if (wr_strb[b])
               data_mem[index][word_off][8*b +: 8] <= wr_data[8*b +: 8];
      end
      // Each 64-bit beat carries the lower word in its low half
      if (fill_en)
      begin
         data_mem[index][{fill_beat, 1'b0}] <= fill_data[cache_geom_pkg::FE_DATA_W-1:0];
         data_mem[index][{fill_beat, 1'b1}] <=
            fill_data[native_bus_pkg::BE_DATA_W-1:cache_geom_pkg::FE_DATA_W];
      end
   end

endmodule

`default_nettype wire

/* verilog/native_mem_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface native_mem_if #(
   parameter int DATA_W = 32
) ();

   logic                                  valid;
   logic [native_bus_pkg::BE_ADDR_W-1:0]  addr;
   logic [DATA_W-1:0]                     wdata;
   logic [DATA_W/8-1:0]                   wstrb;
   logic                                  ready;
   logic [DATA_W-1:0]                     rdata;

   // Valid and payload hold until the cycle where ready is high
   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rdata
   );

endinterface

`default_nettype wire

/* verilog/native_bus_pkg.sv */
`default_nettype none

package native_bus_pkg;

   localparam int BE_ADDR_W = 16;
   localparam int BE_DATA_W = 64;
   localparam int BE_NBYTES = BE_DATA_W / 8;
   localparam int BE_BYTE_W = $clog2(BE_NBYTES);

   // A 16-byte line takes two 64-bit beats
   localparam int BEATS_PER_LINE = 2;

   localparam int WBUF_DEPTH = 4;
   localparam int WBUF_PTR_W = $clog2(WBUF_DEPTH);

endpackage

`default_nettype wire

/* verilog/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

   // Front-end byte address and word size
   localparam int FE_ADDR_W = 16;
   localparam int FE_DATA_W = 32;
   localparam int FE_NBYTES = FE_DATA_W / 8;

   // Four words per line and sixteen lines
   localparam int WORD_OFF_W = 2;
   localparam int INDEX_W = 4;

   // Whatever sits above index, word offset and byte offset is the tag
   localparam int TAG_W = FE_ADDR_W - INDEX_W - WORD_OFF_W - $clog2(FE_NBYTES);

endpackage

`default_nettype wire
